// File: design/la_core_config.svh
`ifndef LA_CORE_CONFIG_SVH
`define LA_CORE_CONFIG_SVH

// data and address width
`define LA_XLEN 32

// architectural integer registers, r0 hardwired to zero
`define LA_NUM_REGS 32

// first fetch address out of reset
`define LA_RESET_PC 32'h1c00_0000

`endif

// File: design/la_core_pkg.sv
`include "la_core_config.svh"

package la_core_pkg;

    typedef logic [`LA_XLEN-1:0] word_t;

    typedef logic [$clog2(`LA_NUM_REGS)-1:0] reg_addr_t;

    // pass_b hands operand two straight through, used by lu12i.w
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

endpackage

// File: design/la_regfile.sv
`include "la_core_config.svh"

module la_regfile import la_core_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    output word_t     rdata1,
    input  reg_addr_t raddr2,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);
    word_t regs [`LA_NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 never written, so force zero on read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: design/la_alu.sv
module la_alu import la_core_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result
);
    word_t sum;
    word_t diff;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = sum;
            ALU_SUB:    result = diff;
            ALU_SLT:    result = word_t'($signed(src1) < $signed(src2));
            ALU_SLTU:   result = word_t'(src1 < src2);
            ALU_AND:    result = src1 & src2;
            ALU_OR:     result = src1 | src2;
            ALU_NOR:    result = ~(src1 | src2);
            ALU_XOR:    result = src1 ^ src2;
            ALU_PASS_B: result = src2;   // lu12i.w
            default:    result = sum;
        endcase
    end

endmodule

// File: design/la_fetch_stage.sv
`include "la_core_config.svh"

module la_fetch_stage import la_core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    output logic  inst_sram_req,
    output word_t inst_sram_addr,
    input  logic  inst_sram_addr_ok,
    input  logic  inst_sram_data_ok,
    input  word_t inst_sram_rdata,
    input  logic  id_allowin,
    input  logic  br_taken,
    input  word_t br_target,
    output logic  if_ready,
    output word_t if_inst,
    output word_t if_pc
);
    logic  fetch_en;     // first request one cycle after reset
    word_t pc;           // next address to request
    logic  in_flight;    // addr accepted, data not back yet
    word_t flight_pc;
    logic  drop_next;    // wrong-path return still on its way
    logic  hold_valid;
    word_t hold_inst;
    word_t hold_pc;
    logic  ret_ok;
    logic  accept;

    assign accept         = inst_sram_req && inst_sram_addr_ok;
    assign ret_ok         = in_flight && inst_sram_data_ok && !drop_next;
    assign inst_sram_req  = fetch_en && !in_flight && !hold_valid;
    assign inst_sram_addr = pc;

    // holding register wins over the bus
    assign if_ready = hold_valid || ret_ok;
    assign if_inst  = hold_valid ? hold_inst : inst_sram_rdata;
    assign if_pc    = hold_valid ? hold_pc : flight_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_en   <= 1'b0;
            pc         <= `LA_RESET_PC;
            in_flight  <= 1'b0;
            drop_next  <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (br_taken) begin
                pc <= br_target;
            end else if (accept) begin
                pc <= pc + word_t'(4);
            end
            if (accept) begin
                in_flight <= 1'b1;
            end else if (in_flight && inst_sram_data_ok) begin
                in_flight <= 1'b0;
            end
            // redirect with the sequential fetch already on the bus
            if (br_taken && ((in_flight && !inst_sram_data_ok) || accept)) begin
                drop_next <= 1'b1;
            end else if (in_flight && inst_sram_data_ok) begin
                drop_next <= 1'b0;
            end
            if (br_taken || (hold_valid && id_allowin)) begin
                hold_valid <= 1'b0;
            end else if (ret_ok && !id_allowin) begin
                hold_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            flight_pc <= pc;
        end
        if (ret_ok && !id_allowin) begin
            hold_inst <= inst_sram_rdata;
            hold_pc   <= flight_pc;
        end
    end

endmodule

// File: design/la_decode_stage.sv
module la_decode_stage import la_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      if_ready,
    input  word_t     if_inst,
    input  word_t     if_pc,
    input  logic      ex_allowin,
    output logic      id_valid,
    output logic      id_ready,
    output logic      id_allowin,
    output logic      br_taken,
    output word_t     br_target,
    output alu_op_t   id_alu_op,
    output word_t     id_src1,
    output word_t     id_src2,
    output word_t     id_store_data,
    output logic      id_is_load,
    output logic      id_is_store,
    output reg_addr_t id_dest,
    output logic      id_wen,
    output word_t     id_pc,
    input  reg_addr_t ex_dest,
    input  reg_addr_t mem_dest,
    input  reg_addr_t wb_dest,
    input  logic      ex_wen,
    input  logic      mem_wen,
    input  logic      wb_wen,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata
);
    word_t     inst;
    reg_addr_t rd, rj, rk;
    reg_addr_t raddr2;
    word_t     rj_value, rkd_value;
    logic      is_3r, is_addi, is_lu12i, is_b, is_bl, is_beq, is_bne;
    logic      src_is_rd, need_rj, need_r2, stall;
    word_t     imm, br_offs;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    // 3r group: op[31:20] = 0x001, funct in [19:15]
    assign is_3r       = inst[31:20] == 12'h001 && inst[19:15] inside {5'h00, 5'h02, 5'h04,
                         5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b};
    assign is_addi     = inst[31:22] == 10'h00a;
    assign is_lu12i    = inst[31:25] == 7'h0a;
    assign id_is_load  = inst[31:22] == 10'h0a2;
    assign id_is_store = inst[31:22] == 10'h0a6;
    assign is_b        = inst[31:26] == 6'h14;
    assign is_bl       = inst[31:26] == 6'h15;
    assign is_beq      = inst[31:26] == 6'h16;
    assign is_bne      = inst[31:26] == 6'h17;

    assign src_is_rd = is_beq || is_bne || id_is_store;
    assign need_rj   = is_3r || is_addi || id_is_load || src_is_rd;
    assign need_r2   = is_3r || src_is_rd;
    assign raddr2    = src_is_rd ? rd : rk;

    la_regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rj_value),
        .raddr2 (raddr2),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // wait until the producer has left writeback, no bypass
    assign stall = (need_rj && rj != '0 && ((ex_wen && rj == ex_dest) ||
                    (mem_wen && rj == mem_dest) || (wb_wen && rj == wb_dest))) ||
                   (need_r2 && raddr2 != '0 && ((ex_wen && raddr2 == ex_dest) ||
                    (mem_wen && raddr2 == mem_dest) || (wb_wen && raddr2 == wb_dest)));
    assign id_ready   = !stall;
    assign id_allowin = !id_valid || (id_ready && ex_allowin);

    always_comb begin
        case (inst[19:15])   // only meaningful when is_3r
            5'h02:   id_alu_op = ALU_SUB;
            5'h04:   id_alu_op = ALU_SLT;
            5'h05:   id_alu_op = ALU_SLTU;
            5'h08:   id_alu_op = ALU_NOR;
            5'h09:   id_alu_op = ALU_AND;
            5'h0a:   id_alu_op = ALU_OR;
            5'h0b:   id_alu_op = ALU_XOR;
            default: id_alu_op = ALU_ADD;
        endcase
        if (!is_3r) id_alu_op = is_lu12i ? ALU_PASS_B : ALU_ADD;
    end

    assign imm = is_bl    ? word_t'(4) :
                 is_lu12i ? {inst[24:5], 12'b0} :
                            {{20{inst[21]}}, inst[21:10]};   // si12
    assign id_src1       = is_bl ? id_pc : rj_value;
    assign id_src2       = is_3r ? rkd_value : imm;
    assign id_store_data = rkd_value;
    assign id_dest       = is_bl ? reg_addr_t'(1) : rd;
    assign id_wen        = is_3r || is_addi || is_lu12i || id_is_load || is_bl;

    assign br_offs   = (is_b || is_bl) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                                       : {{14{inst[25]}}, inst[25:10], 2'b0};
    assign br_target = id_pc + br_offs;
    // one-shot, only in the cycle the branch leaves decode
    assign br_taken  = id_valid && id_ready && ex_allowin && (is_b || is_bl ||
                       (is_beq && rj_value == rkd_value) || (is_bne && rj_value != rkd_value));

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= if_ready && !br_taken;   // drop the wrong-path slot
        end
    end

    always_ff @(posedge clk) begin
        if (id_allowin && if_ready) begin
            inst  <= if_inst;
            id_pc <= if_pc;
        end
    end

endmodule

// File: design/la_execute_stage.sv
module la_execute_stage import la_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      id_valid,
    input  logic      id_ready,
    input  alu_op_t   id_alu_op,
    input  word_t     id_src1,
    input  word_t     id_src2,
    input  word_t     id_store_data,
    input  logic      id_is_load,
    input  logic      id_is_store,
    input  reg_addr_t id_dest,
    input  logic      id_wen,
    input  word_t     id_pc,
    input  logic      mem_allowin,
    output logic      ex_allowin,
    output logic      ex_valid,
    output word_t     ex_result,
    output word_t     ex_store_data,
    output logic      ex_is_load,
    output logic      ex_is_store,
    output reg_addr_t ex_dest,
    output logic      ex_wen,
    output word_t     ex_pc
);
    alu_op_t alu_op;
    word_t   src1;
    word_t   src2;
    logic    wen_r;

    assign ex_allowin = !ex_valid || mem_allowin;   // single-cycle, always ready
    assign ex_wen     = wen_r && ex_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= id_valid && id_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_allowin && id_valid && id_ready) begin
            alu_op        <= id_alu_op;
            src1          <= id_src1;
            src2          <= id_src2;
            ex_store_data <= id_store_data;
            ex_is_load    <= id_is_load;
            ex_is_store   <= id_is_store;
            ex_dest       <= id_dest;
            wen_r         <= id_wen;
            ex_pc         <= id_pc;
        end
    end

    la_alu u_alu (
        .alu_op (alu_op),
        .src1   (src1),
        .src2   (src2),
        .result (ex_result)
    );

endmodule

// File: design/la_memory_stage.sv
module la_memory_stage import la_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ex_valid,
    input  word_t     ex_result,
    input  word_t     ex_store_data,
    input  logic      ex_is_load,
    input  logic      ex_is_store,
    input  reg_addr_t ex_dest,
    input  logic      ex_wen,
    input  word_t     ex_pc,
    output logic      mem_allowin,
    output logic      data_sram_req,
    output logic      data_sram_wr,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    input  logic      data_sram_addr_ok,
    input  logic      data_sram_data_ok,
    input  word_t     data_sram_rdata,
    output reg_addr_t mem_dest,
    output logic      mem_wen,
    output reg_addr_t wb_dest,
    output logic      wb_wen,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    output word_t     wb_pc
);
    logic  mem_valid;
    word_t mem_result;   // alu result, also the data address
    word_t mem_wdata;
    logic  mem_is_load;
    logic  mem_is_store;
    logic  mem_wen_r;
    word_t mem_pc;
    logic  mem_access;
    logic  addr_acc;     // waiting for data_ok
    logic  mem_ready;
    logic  wb_valid;
    logic  wb_wen_r;
    word_t wb_data;

    assign mem_access  = mem_is_load || mem_is_store;
    assign mem_ready   = !mem_access || (addr_acc && data_sram_data_ok);
    assign mem_allowin = !mem_valid || mem_ready;   // writeback never stalls
    assign mem_wen     = mem_valid && mem_wen_r;

    assign data_sram_req   = mem_valid && mem_access && !addr_acc;
    assign data_sram_wr    = mem_valid && mem_is_store;
    assign data_sram_addr  = mem_result;
    assign data_sram_wdata = mem_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
            addr_acc  <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            if (mem_allowin) mem_valid <= ex_valid;
            if (addr_acc && data_sram_data_ok) begin
                addr_acc <= 1'b0;
            end else if (data_sram_req && data_sram_addr_ok) begin
                addr_acc <= 1'b1;
            end
            wb_valid <= mem_valid && mem_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_allowin && ex_valid) begin
            mem_result   <= ex_result;
            mem_wdata    <= ex_store_data;
            mem_is_load  <= ex_is_load;
            mem_is_store <= ex_is_store;
            mem_dest     <= ex_dest;
            mem_wen_r    <= ex_wen;
            mem_pc       <= ex_pc;
        end
        if (mem_valid && mem_ready) begin
            wb_data  <= mem_is_load ? data_sram_rdata : mem_result;   // load word lands here
            wb_dest  <= mem_dest;
            wb_wen_r <= mem_wen_r;
            wb_pc    <= mem_pc;
        end
    end

    assign wb_wen   = wb_valid && wb_wen_r;
    assign rf_we    = wb_wen;
    assign rf_waddr = wb_dest;
    assign rf_wdata = wb_data;

endmodule

// File: design/la_core_top.sv
module la_core_top import la_core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       inst_sram_req,
    output word_t      inst_sram_addr,
    input  logic       inst_sram_addr_ok,
    input  logic       inst_sram_data_ok,
    input  word_t      inst_sram_rdata,
    output logic       data_sram_req,
    output logic       data_sram_wr,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  logic       data_sram_addr_ok,
    input  logic       data_sram_data_ok,
    input  word_t      data_sram_rdata,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);
    logic      if_ready, id_valid, id_ready, id_allowin, ex_allowin, mem_allowin, br_taken;
    word_t     if_inst, if_pc, br_target;
    alu_op_t   id_alu_op;
    word_t     id_src1, id_src2, id_store_data, id_pc;
    logic      id_is_load, id_is_store, id_wen;
    reg_addr_t id_dest;
    logic      ex_valid, ex_is_load, ex_is_store, ex_wen;
    word_t     ex_result, ex_store_data, ex_pc;
    reg_addr_t ex_dest, mem_dest, wb_dest;
    logic      mem_wen, wb_wen, rf_we;

    la_fetch_stage u_fetch (
        .clk, .reset, .inst_sram_req, .inst_sram_addr, .inst_sram_addr_ok,
        .inst_sram_data_ok, .inst_sram_rdata, .id_allowin, .br_taken, .br_target,
        .if_ready, .if_inst, .if_pc
    );

    la_decode_stage u_decode (
        .clk, .reset, .if_ready, .if_inst, .if_pc, .ex_allowin, .id_valid, .id_ready,
        .id_allowin, .br_taken, .br_target, .id_alu_op, .id_src1, .id_src2,
        .id_store_data, .id_is_load, .id_is_store, .id_dest, .id_wen, .id_pc,
        .ex_dest, .mem_dest, .wb_dest, .ex_wen, .mem_wen, .wb_wen,
        .rf_we, .rf_waddr(debug_wb_rf_wnum), .rf_wdata(debug_wb_rf_wdata)
    );

    la_execute_stage u_execute (
        .clk, .reset, .id_valid, .id_ready, .id_alu_op, .id_src1, .id_src2,
        .id_store_data, .id_is_load, .id_is_store, .id_dest, .id_wen, .id_pc,
        .mem_allowin, .ex_allowin, .ex_valid, .ex_result, .ex_store_data,
        .ex_is_load, .ex_is_store, .ex_dest, .ex_wen, .ex_pc
    );

    la_memory_stage u_memory (
        .clk, .reset, .ex_valid, .ex_result, .ex_store_data, .ex_is_load, .ex_is_store,
        .ex_dest, .ex_wen, .ex_pc, .mem_allowin, .data_sram_req, .data_sram_wr,
        .data_sram_addr, .data_sram_wdata, .data_sram_addr_ok, .data_sram_data_ok,
        .data_sram_rdata, .mem_dest, .mem_wen, .wb_dest, .wb_wen, .rf_we,
        .rf_waddr(debug_wb_rf_wnum), .rf_wdata(debug_wb_rf_wdata), .wb_pc(debug_wb_pc)
    );

    assign debug_wb_rf_we = {4{rf_we}};   // trace port wants a byte-lane mask

endmodule

// File: dv/la_sram_model.sv
module la_sram_model import la_core_pkg::*; #(
    parameter logic [31:0] SEED = 32'h7737_25c8
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  req,
    input  logic  wr,
    input  word_t addr,
    input  word_t wdata,
    output logic  addr_ok,
    output logic  data_ok,
    output word_t rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    word_t      mem [1024];   // indexed by addr[11:2]
    int         phase;        // 0 idle, 1 address wait, 2 data wait
    int         delay;
    logic       acc_wr;
    word_t      acc_addr;
    word_t      acc_wdata;

    initial begin
        void'($urandom(SEED));
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = '0;
        phase   = 0;
        delay   = 0;
    end

    // strobes change only on the falling edge
    always @(negedge clk) begin
        addr_ok <= 1'b0;
        data_ok <= 1'b0;
        if (reset) begin
            phase = 0;
        end else if (phase == 2) begin
            if (delay == 0) begin
                data_ok <= 1'b1;
                if (acc_wr) begin
                    mem[acc_addr[11:2]] = acc_wdata;
                end else begin
                    rdata <= mem[acc_addr[11:2]];
                end
                phase = 0;
            end else begin
                delay--;
            end
        end else begin
            if (phase == 0 && req) begin
                delay = int'($urandom % 4);
                phase = 1;
            end
            if (phase == 1) begin
                if (delay == 0) begin
                    addr_ok  <= 1'b1;   // core holds req, so this accepts at the next edge
                    acc_wr    = wr;
                    acc_addr  = addr;
                    acc_wdata = wdata;
                    delay     = int'($urandom % 4);
                    phase     = 2;
                end else begin
                    delay--;
                end
            end
        end
    end

endmodule

// File: dv/la_core_tb.sv
`include "la_core_config.svh"

module la_core_tb import la_core_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROWS = 28;

    logic       clk;
    logic       reset;
    logic       inst_sram_req, inst_sram_addr_ok, inst_sram_data_ok;
    word_t      inst_sram_addr, inst_sram_rdata;
    logic       data_sram_req, data_sram_wr, data_sram_addr_ok, data_sram_data_ok;
    word_t      data_sram_addr, data_sram_wdata, data_sram_rdata;
    word_t      debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_we;
    reg_addr_t  debug_wb_rf_wnum;

    // one row per program word: instruction, writes a register, which, what value
    word_t      prog [ROWS];
    logic       writes [ROWS];
    reg_addr_t  dest [ROWS];
    word_t      value [ROWS];
    int         errors;
    int         checks;
    logic       timed_out;
    logic       seen;

    la_core_top DUT (.*);

    la_sram_model u_imem (
        .clk, .reset, .req(inst_sram_req), .wr(1'b0), .addr(inst_sram_addr),
        .wdata('0), .addr_ok(inst_sram_addr_ok), .data_ok(inst_sram_data_ok),
        .rdata(inst_sram_rdata)
    );

    la_sram_model u_dmem (
        .clk, .reset, .req(data_sram_req), .wr(data_sram_wr), .addr(data_sram_addr),
        .wdata(data_sram_wdata), .addr_ok(data_sram_addr_ok),
        .data_ok(data_sram_data_ok), .rdata(data_sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t r3_word(logic [16:0] op, int rd, int rj, int rk);
        return {op, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic word_t ri12_word(logic [9:0] op, int rd, int rj, logic [11:0] imm);
        return {op, imm, 5'(rj), 5'(rd)};
    endfunction

    function automatic word_t lu12i_word(int rd, logic [19:0] imm);
        return {7'h0a, imm, 5'(rd)};
    endfunction

    function automatic word_t branch16_word(logic [5:0] op, int rj, int rd, logic [15:0] offs);
        return {op, offs, 5'(rj), 5'(rd)};
    endfunction

    function automatic word_t branch26_word(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic set_row(int i, word_t inst, logic wr, int rd, word_t val);
        prog[i]   = inst;
        writes[i] = wr;
        dest[i]   = reg_addr_t'(rd);
        value[i]  = val;
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_idle();
        check_word("debug_wb_rf_we", word_t'(debug_wb_rf_we), '0);
        check_word("inst_sram_req", word_t'(inst_sram_req), '0);
        check_word("data_sram_req", word_t'(data_sram_req), '0);
    endtask

    task automatic wait_for_write(output logic found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < 400) begin
            @(negedge clk);
            cycles++;
            if (debug_wb_rf_we != 4'b0) found = 1'b1;
        end
    endtask

    initial begin
        reset     = 1'b1;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;

        set_row(0,  ri12_word(10'h00a, 1, 0, 12'h7ff), 1, 1, 32'h0000_07ff);
        set_row(1,  ri12_word(10'h00a, 2, 0, 12'hffb), 1, 2, 32'hffff_fffb);
        set_row(2,  r3_word(17'h00020, 3, 1, 2), 1, 3, 32'h0000_07fa);   // add.w, depends on r2
        set_row(3,  r3_word(17'h00022, 4, 1, 2), 1, 4, 32'h0000_0804);
        set_row(4,  r3_word(17'h00024, 5, 2, 1), 1, 5, 32'h0000_0001);   // signed -5 < 0x7ff
        set_row(5,  r3_word(17'h00025, 6, 2, 1), 1, 6, 32'h0000_0000);
        set_row(6,  r3_word(17'h00029, 7, 1, 2), 1, 7, 32'h0000_07fb);
        set_row(7,  r3_word(17'h0002a, 8, 1, 2), 1, 8, 32'hffff_ffff);
        set_row(8,  r3_word(17'h00028, 9, 1, 2), 1, 9, 32'h0000_0000);
        set_row(9,  r3_word(17'h0002b, 10, 1, 2), 1, 10, 32'hffff_f804);
        set_row(10, lu12i_word(11, 20'h12345), 1, 11, 32'h1234_5000);
        set_row(11, ri12_word(10'h00a, 0, 0, 12'h055), 1, 0, 32'h0000_0055);
        set_row(12, r3_word(17'h00020, 12, 0, 1), 1, 12, 32'h0000_07ff);   // r0 still zero
        set_row(13, ri12_word(10'h00a, 13, 11, 12'h678), 1, 13, 32'h1234_5678);
        set_row(14, ri12_word(10'h0a6, 13, 0, 12'h100), 0, 0, '0);         // st.w
        set_row(15, ri12_word(10'h0a2, 14, 0, 12'h100), 1, 14, 32'h1234_5678);
        set_row(16, branch26_word(6'h14, 26'd2), 0, 0, '0);
        set_row(17, ri12_word(10'h00a, 15, 0, 12'h001), 0, 0, '0);          // skipped
        set_row(18, branch26_word(6'h15, 26'd2), 1, 1, 32'h1c00_004c);    // bl
        set_row(19, ri12_word(10'h00a, 15, 0, 12'h002), 0, 0, '0);
        set_row(20, branch16_word(6'h16, 14, 13, 16'd2), 0, 0, '0);        // beq taken
        set_row(21, ri12_word(10'h00a, 15, 0, 12'h003), 0, 0, '0);
        set_row(22, branch16_word(6'h17, 14, 13, 16'd3), 0, 0, '0);        // bne falls through
        set_row(23, branch16_word(6'h16, 3, 4, 16'd2), 0, 0, '0);          // beq falls through
        set_row(24, branch16_word(6'h17, 3, 4, 16'd2), 0, 0, '0);          // bne taken
        set_row(25, ri12_word(10'h00a, 15, 0, 12'h004), 0, 0, '0);
        set_row(26, ri12_word(10'h00a, 16, 1, 12'h004), 1, 16, 32'h1c00_0050);
        set_row(27, branch26_word(6'h14, 26'd0), 0, 0, '0);                // spin here

        for (int i = 0; i < ROWS; i++) begin
            u_imem.mem[i] = prog[i];   // reset pc has addr[11:2] of zero
        end

        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
        reset = 1'b0;
        check_idle();

        for (int i = 0; i < ROWS; i++) begin
            if (writes[i]) begin
                wait_for_write(seen);
                if (!seen) begin
                    $display("timeout waiting for the register write of pc %h",
                             `LA_RESET_PC + word_t'(4 * i));
                    timed_out = 1'b1;
                    break;
                end
                check_word("debug_wb_rf_we", word_t'(debug_wb_rf_we), 32'h0000_000f);
                check_word("debug_wb_pc", debug_wb_pc, `LA_RESET_PC + word_t'(4 * i));
                check_word("debug_wb_rf_wnum", word_t'(debug_wb_rf_wnum), word_t'(dest[i]));
                check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, value[i]);
            end
        end

        if (!timed_out) begin
            // the spin loop must retire nothing more
            repeat (60) begin
                @(negedge clk);
                if (debug_wb_rf_we != 4'b0) begin
                    errors++;
                    $display("unexpected extra register write from pc %h", debug_wb_pc);
                end
            end
            check_word("dmem word 0x100", u_dmem.mem[10'h040], 32'h1234_5678);
        end

        $display("checks: %0d errors: %0d timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+design
design/la_core_pkg.sv
design/la_regfile.sv
design/la_alu.sv
design/la_fetch_stage.sv
design/la_decode_stage.sv
design/la_execute_stage.sv
design/la_memory_stage.sv
design/la_core_top.sv
dv/la_sram_model.sv
dv/la_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module la_core_tb -f flist.f -o la_core_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/la_core_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
